// File: Bender.yml
package:
  name: decode_stage

sources:
  - holy_core_pkg.sv
  - main_control.sv
  - alu_control.sv
  - sign_extend.sv
  - control.sv
  - decode_stage.sv
  - target: test
    files:
      - tb_decode_stage.sv

// File: alu_control.sv
`timescale 1ns/1ps

module alu_control import holy_core_pkg::*; (
    input  alu_op_t      alu_op,
    input  func3_t       func3,
    input  logic         func7_b5,
    input  logic         r_type,
    output alu_control_t alu_control
);

    always_comb begin
        alu_control = ALU_ADD;

        case (alu_op)
            ALU_OP_LOAD_STORE: begin
                // Address generation is a plain add.
                alu_control = ALU_ADD;
            end
            ALU_OP_BRANCHES: begin
                case (func3)
                    BEQ, BNE:   alu_control = ALU_SUB;
                    BLT, BGE:   alu_control = ALU_SLT;
                    BLTU, BGEU: alu_control = ALU_SLTU;
                    default:    alu_control = ALU_SUB;
                endcase
            end
            ALU_OP_R_TYPE, ALU_OP_I_TYPE: begin
                case (func3)
                    F3_ADD_SUB: begin
                        // ADDI has no SUB form, so bit 30 only counts for R-type.
                        if (r_type && func7_b5) begin
                            alu_control = ALU_SUB;
                        end else begin
                            alu_control = ALU_ADD;
                        end
                    end
                    F3_SLL:  alu_control = ALU_SLL;
                    F3_SLT:  alu_control = ALU_SLT;
                    F3_SLTU: alu_control = ALU_SLTU;
                    F3_XOR:  alu_control = ALU_XOR;
                    F3_SRL_SRA: begin
                        // SRAI carries the same bit 30 as SRA.
                        if (func7_b5) begin
                            alu_control = ALU_SRA;
                        end else begin
                            alu_control = ALU_SRL;
                        end
                    end
                    F3_OR:   alu_control = ALU_OR;
                    F3_AND:  alu_control = ALU_AND;
                    default: alu_control = ALU_ADD;
                endcase
            end
            default: begin
                alu_control = ALU_ADD;
            end
        endcase
    end

endmodule

// File: control.sv
`timescale 1ns/1ps

module control import holy_core_pkg::*; (
    input  logic [6:0]   opcode,
    input  func3_t       func3,
    input  logic         func7_b5,
    input  logic         alu_zero,
    input  logic         alu_last_bit,
    output logic         mem_write,
    output logic         reg_write,
    output logic         alu_source,
    output imm_source_t  imm_source,
    output alu_op_t      alu_op,
    output logic         r_type,
    output logic         branch,
    output logic         jump,
    output logic         jalr,
    output logic         lui,
    output logic         auipc,
    output logic         mem_to_reg,
    output logic         illegal,
    output alu_control_t alu_control,
    output pc_source_t   pc_source
);

    logic branch_cond;

    main_control main_control_i (
        .opcode     (opcode),
        .mem_write  (mem_write),
        .reg_write  (reg_write),
        .alu_source (alu_source),
        .imm_source (imm_source),
        .alu_op     (alu_op),
        .r_type     (r_type),
        .branch     (branch),
        .jump       (jump),
        .jalr       (jalr),
        .lui        (lui),
        .auipc      (auipc),
        .mem_to_reg (mem_to_reg),
        .illegal    (illegal)
    );

    alu_control alu_control_i (
        .alu_op      (alu_op),
        .func3       (func3),
        .func7_b5    (func7_b5),
        .r_type      (r_type),
        .alu_control (alu_control)
    );

    // The ALU subtracts for BEQ/BNE and sets bit 0 on less-than for the others.
    always_comb begin
        case (func3)
            BEQ:        branch_cond = alu_zero;
            BNE:        branch_cond = ~alu_zero;
            BLT, BLTU:  branch_cond = alu_last_bit;
            BGE, BGEU:  branch_cond = ~alu_last_bit;
            default:    branch_cond = 1'b0;
        endcase
    end

    assign pc_source = (jump || (branch && branch_cond)) ? PC_TARGET : PC_PLUS_4;

endmodule

// File: decode_stage.f
holy_core_pkg.sv
main_control.sv
alu_control.sv
sign_extend.sv
control.sv
decode_stage.sv
tb_decode_stage.sv

// File: decode_stage.sv
`timescale 1ns/1ps

module decode_stage import holy_core_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         in_valid,
    input  logic         stall,
    input  word_t        instr,
    input  logic         alu_zero,
    input  logic         alu_last_bit,
    output logic         out_valid,
    output word_t        instr_q,
    output word_t        imm,
    output logic         mem_write,
    output logic         reg_write,
    output logic         alu_source,
    output imm_source_t  imm_source,
    output alu_op_t      alu_op,
    output logic         r_type,
    output logic         branch,
    output logic         jump,
    output logic         jalr,
    output logic         lui,
    output logic         auipc,
    output logic         mem_to_reg,
    output logic         illegal,
    output alu_control_t alu_control,
    output pc_source_t   pc_source
);

    logic [6:0] opcode;
    func3_t     func3;
    logic       func7_b5;

    // Stage register. A stall freezes both the instruction and its valid bit,
    // and reset loads a NOP so the decode outputs are harmless.
    always_ff @(posedge clk) begin
        if (rst) begin
            instr_q   <= NOP_INSTR;
            out_valid <= 1'b0;
        end else if (!stall) begin
            instr_q   <= instr;
            out_valid <= in_valid;
        end
    end

    assign opcode   = instr_q[6:0];
    assign func3    = instr_q[14:12];
    assign func7_b5 = instr_q[30];

    control control_i (
        .opcode       (opcode),
        .func3        (func3),
        .func7_b5     (func7_b5),
        .alu_zero     (alu_zero),
        .alu_last_bit (alu_last_bit),
        .mem_write    (mem_write),
        .reg_write    (reg_write),
        .alu_source   (alu_source),
        .imm_source   (imm_source),
        .alu_op       (alu_op),
        .r_type       (r_type),
        .branch       (branch),
        .jump         (jump),
        .jalr         (jalr),
        .lui          (lui),
        .auipc        (auipc),
        .mem_to_reg   (mem_to_reg),
        .illegal      (illegal),
        .alu_control  (alu_control),
        .pc_source    (pc_source)
    );

    sign_extend sign_extend_i (
        .instr      (instr_q),
        .imm_source (imm_source),
        .imm        (imm)
    );

endmodule

// File: holy_core_pkg.sv
package holy_core_pkg;

    // Word type for instructions and immediates of the 32-bit ISA.
    typedef logic [31:0] word_t;

    // Funct3 field of the instruction word.
    typedef logic [2:0] func3_t;

    // Major opcodes of the RV32I base set handled by the decoder.
    typedef enum logic [6:0] {
        OPCODE_R_TYPE       = 7'b0110011,
        OPCODE_I_TYPE_ALU   = 7'b0010011,
        OPCODE_I_TYPE_LOAD  = 7'b0000011,
        OPCODE_S_TYPE       = 7'b0100011,
        OPCODE_B_TYPE       = 7'b1100011,
        OPCODE_U_TYPE_LUI   = 7'b0110111,
        OPCODE_U_TYPE_AUIPC = 7'b0010111,
        OPCODE_J_TYPE       = 7'b1101111,
        OPCODE_J_TYPE_JALR  = 7'b1100111
    } opcode_t;

    // Operation class handed from the main decoder to the ALU decoder.
    typedef enum logic [1:0] {
        ALU_OP_LOAD_STORE = 2'b00,
        ALU_OP_BRANCHES   = 2'b01,
        ALU_OP_R_TYPE     = 2'b10,
        ALU_OP_I_TYPE     = 2'b11
    } alu_op_t;

    // Operation code understood by the execute stage ALU.
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b0001,
        ALU_AND  = 4'b0010,
        ALU_OR   = 4'b0011,
        ALU_SLL  = 4'b0100,
        ALU_SLT  = 4'b0101,
        ALU_SRL  = 4'b0110,
        ALU_SLTU = 4'b0111,
        ALU_XOR  = 4'b1000,
        ALU_SRA  = 4'b1001
    } alu_control_t;

    // Immediate format select for the sign extender.
    typedef logic [2:0] imm_source_t;

    localparam imm_source_t IMM_I = 3'b000;
    localparam imm_source_t IMM_S = 3'b001;
    localparam imm_source_t IMM_B = 3'b010;
    localparam imm_source_t IMM_J = 3'b011;
    localparam imm_source_t IMM_U = 3'b100;

    // Next PC select.
    typedef logic [0:0] pc_source_t;

    localparam pc_source_t PC_PLUS_4 = 1'b0;
    localparam pc_source_t PC_TARGET = 1'b1;

    // Branch conditions carried in funct3.
    localparam func3_t BEQ  = 3'b000;
    localparam func3_t BNE  = 3'b001;
    localparam func3_t BLT  = 3'b100;
    localparam func3_t BGE  = 3'b101;
    localparam func3_t BLTU = 3'b110;
    localparam func3_t BGEU = 3'b111;

    // Integer ALU operations carried in funct3.
    localparam func3_t F3_ADD_SUB = 3'b000;
    localparam func3_t F3_SLL     = 3'b001;
    localparam func3_t F3_SLT     = 3'b010;
    localparam func3_t F3_SLTU    = 3'b011;
    localparam func3_t F3_XOR     = 3'b100;
    localparam func3_t F3_SRL_SRA = 3'b101;
    localparam func3_t F3_OR      = 3'b110;
    localparam func3_t F3_AND     = 3'b111;

    // ADDI x0, x0, 0.
    localparam word_t NOP_INSTR = 32'h0000_0013;

endpackage

// File: main_control.sv
`timescale 1ns/1ps

module main_control import holy_core_pkg::*; (
    input  logic [6:0]  opcode,
    output logic        mem_write,
    output logic        reg_write,
    output logic        alu_source,
    output imm_source_t imm_source,
    output alu_op_t     alu_op,
    output logic        r_type,
    output logic        branch,
    output logic        jump,
    output logic        jalr,
    output logic        lui,
    output logic        auipc,
    output logic        mem_to_reg,
    output logic        illegal
);

    opcode_t opcode_enum;

    assign opcode_enum = opcode_t'(opcode);

    always_comb begin
        // Everything starts inactive, so an unknown opcode writes nothing.
        mem_write  = 1'b0;
        reg_write  = 1'b0;
        alu_source = 1'b0;
        imm_source = IMM_I;
        alu_op     = ALU_OP_LOAD_STORE;
        r_type     = 1'b0;
        branch     = 1'b0;
        jump       = 1'b0;
        jalr       = 1'b0;
        lui        = 1'b0;
        auipc      = 1'b0;
        mem_to_reg = 1'b0;
        illegal    = 1'b0;

        case (opcode_enum)
            OPCODE_R_TYPE: begin
                reg_write = 1'b1;
                alu_op    = ALU_OP_R_TYPE;
                r_type    = 1'b1;
            end
            OPCODE_I_TYPE_ALU: begin
                imm_source = IMM_I;
                reg_write  = 1'b1;
                alu_source = 1'b1;
                alu_op     = ALU_OP_I_TYPE;
            end
            OPCODE_I_TYPE_LOAD: begin
                imm_source = IMM_I;
                reg_write  = 1'b1;
                alu_source = 1'b1;
                mem_to_reg = 1'b1;
            end
            OPCODE_S_TYPE: begin
                imm_source = IMM_S;
                mem_write  = 1'b1;
                alu_source = 1'b1;
            end
            OPCODE_B_TYPE: begin
                // The ALU compares the two registers, the target adder uses the immediate.
                imm_source = IMM_B;
                alu_op     = ALU_OP_BRANCHES;
                branch     = 1'b1;
            end
            OPCODE_U_TYPE_LUI: begin
                imm_source = IMM_U;
                reg_write  = 1'b1;
                lui        = 1'b1;
            end
            OPCODE_U_TYPE_AUIPC: begin
                imm_source = IMM_U;
                reg_write  = 1'b1;
                alu_source = 1'b1;
                auipc      = 1'b1;
            end
            OPCODE_J_TYPE: begin
                imm_source = IMM_J;
                reg_write  = 1'b1;
                jump       = 1'b1;
            end
            OPCODE_J_TYPE_JALR: begin
                imm_source = IMM_I;
                reg_write  = 1'b1;
                jump       = 1'b1;
                jalr       = 1'b1;
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
    end

endmodule

// File: sign_extend.sv
`timescale 1ns/1ps

module sign_extend import holy_core_pkg::*; (
    input  word_t       instr,
    input  imm_source_t imm_source,
    output word_t       imm
);

    logic sign;

    // Every RV32 immediate takes its sign from bit 31 of the instruction.
    assign sign = instr[31];

    always_comb begin
        case (imm_source)
            IMM_I: begin
                imm = {{20{sign}}, instr[31:20]};
            end
            IMM_S: begin
                imm = {{20{sign}}, instr[31:25], instr[11:7]};
            end
            IMM_B: begin
                // Branch offsets are in half words, bit 0 is always zero.
                imm = {{20{sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            IMM_J: begin
                imm = {{12{sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            IMM_U: begin
                imm = {instr[31:12], 12'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

// File: tb_decode_stage.sv
`timescale 1ns/1ps

module tb_decode_stage import holy_core_pkg::*; ();

    localparam int CLK_PERIOD = 100;
    localparam int N_ITEMS    = 800;

    // Expected control bundle for one registered instruction.
    typedef struct packed {
        logic         mem_write;
        logic         reg_write;
        logic         alu_source;
        imm_source_t  imm_source;
        alu_op_t      alu_op;
        logic         r_type;
        logic         branch;
        logic         jump;
        logic         jalr;
        logic         lui;
        logic         auipc;
        logic         mem_to_reg;
        logic         illegal;
        alu_control_t alu_control;
        pc_source_t   pc_source;
        word_t        imm;
    } bundle_t;

    logic         clk;
    logic         rst;
    logic         in_valid;
    logic         stall;
    word_t        instr;
    logic         alu_zero;
    logic         alu_last_bit;
    logic         out_valid;
    word_t        instr_q;
    word_t        imm;
    logic         mem_write;
    logic         reg_write;
    logic         alu_source;
    imm_source_t  imm_source;
    alu_op_t      alu_op;
    logic         r_type;
    logic         branch;
    logic         jump;
    logic         jalr;
    logic         lui;
    logic         auipc;
    logic         mem_to_reg;
    logic         illegal;
    alu_control_t alu_control;
    pc_source_t   pc_source;

    word_t       exp_instr;
    logic        exp_valid;
    logic        checking;
    int unsigned seed_dummy;

    decode_stage dut0 (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .stall        (stall),
        .instr        (instr),
        .alu_zero     (alu_zero),
        .alu_last_bit (alu_last_bit),
        .out_valid    (out_valid),
        .instr_q      (instr_q),
        .imm          (imm),
        .mem_write    (mem_write),
        .reg_write    (reg_write),
        .alu_source   (alu_source),
        .imm_source   (imm_source),
        .alu_op       (alu_op),
        .r_type       (r_type),
        .branch       (branch),
        .jump         (jump),
        .jalr         (jalr),
        .lui          (lui),
        .auipc        (auipc),
        .mem_to_reg   (mem_to_reg),
        .illegal      (illegal),
        .alu_control  (alu_control),
        .pc_source    (pc_source)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic report_failure();
        $display("Testbench failed");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED at %0t: %s expected %0b, got %0b", $time, name, exp, act);
            report_failure();
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
            report_failure();
        end
    endtask

    task automatic check_alu(input string name, input alu_control_t exp,
                             input alu_control_t act);
        if (act !== exp) begin
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
            report_failure();
        end
    endtask

    task automatic check_alu_op(input string name, input alu_op_t exp,
                                input alu_op_t act);
        if (act !== exp) begin
            $display("FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
            report_failure();
        end
    endtask

    task automatic check_imm_src(input string name, input imm_source_t exp,
                                 input imm_source_t act);
        if (act !== exp) begin
            $display("FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
            report_failure();
        end
    endtask

    function automatic logic legal_opcode(input logic [6:0] op);
        case (op)
            OPCODE_R_TYPE, OPCODE_I_TYPE_ALU, OPCODE_I_TYPE_LOAD, OPCODE_S_TYPE,
            OPCODE_B_TYPE, OPCODE_U_TYPE_LUI, OPCODE_U_TYPE_AUIPC, OPCODE_J_TYPE,
            OPCODE_J_TYPE_JALR: return 1'b1;
            default:            return 1'b0;
        endcase
    endfunction

    // Kinds 0 to 8 pick a legal opcode, anything else an illegal one.
    function automatic word_t make_instr(input int kind);
        word_t      w;
        logic [6:0] op;
        w = $urandom;
        case (kind)
            0:       op = OPCODE_R_TYPE;
            1:       op = OPCODE_I_TYPE_ALU;
            2:       op = OPCODE_I_TYPE_LOAD;
            3:       op = OPCODE_S_TYPE;
            4:       op = OPCODE_B_TYPE;
            5:       op = OPCODE_U_TYPE_LUI;
            6:       op = OPCODE_U_TYPE_AUIPC;
            7:       op = OPCODE_J_TYPE;
            8:       op = OPCODE_J_TYPE_JALR;
            default: begin
                op = $urandom_range(0, 127);
                while (legal_opcode(op)) begin
                    op = $urandom_range(0, 127);
                end
            end
        endcase
        return {w[31:7], op};
    endfunction

    function automatic bundle_t decode_ref(input word_t ins, input logic zero,
                                           input logic last_bit);
        bundle_t           b;
        logic [2:0]        f3;
        logic signed [31:0] simm;
        logic              taken;
        b = '0;
        f3 = ins[14:12];
        b.imm_source = IMM_I;
        b.alu_op = ALU_OP_LOAD_STORE;
        b.alu_control = ALU_ADD;
        case (ins[6:0])
            OPCODE_R_TYPE: begin
                b.reg_write = 1'b1;
                b.r_type = 1'b1;
                b.alu_op = ALU_OP_R_TYPE;
            end
            OPCODE_I_TYPE_ALU: begin
                b.reg_write = 1'b1;
                b.alu_source = 1'b1;
                b.alu_op = ALU_OP_I_TYPE;
            end
            OPCODE_I_TYPE_LOAD: begin
                b.reg_write = 1'b1;
                b.alu_source = 1'b1;
                b.mem_to_reg = 1'b1;
            end
            OPCODE_S_TYPE: begin
                b.imm_source = IMM_S;
                b.mem_write = 1'b1;
                b.alu_source = 1'b1;
            end
            OPCODE_B_TYPE: begin
                b.imm_source = IMM_B;
                b.branch = 1'b1;
                b.alu_op = ALU_OP_BRANCHES;
            end
            OPCODE_U_TYPE_LUI: begin
                b.imm_source = IMM_U;
                b.reg_write = 1'b1;
                b.lui = 1'b1;
            end
            OPCODE_U_TYPE_AUIPC: begin
                b.imm_source = IMM_U;
                b.reg_write = 1'b1;
                b.alu_source = 1'b1;
                b.auipc = 1'b1;
            end
            OPCODE_J_TYPE: begin
                b.imm_source = IMM_J;
                b.reg_write = 1'b1;
                b.jump = 1'b1;
            end
            OPCODE_J_TYPE_JALR: begin
                b.reg_write = 1'b1;
                b.jump = 1'b1;
                b.jalr = 1'b1;
            end
            default: b.illegal = 1'b1;
        endcase

        // Branches compare with SUB, SLT or SLTU depending on func3 bits 2:1.
        if (b.branch) begin
            if (f3[2:1] == 2'b10) begin
                b.alu_control = ALU_SLT;
            end else if (f3[2:1] == 2'b11) begin
                b.alu_control = ALU_SLTU;
            end else begin
                b.alu_control = ALU_SUB;
            end
        end else if (ins[6:0] == OPCODE_R_TYPE || ins[6:0] == OPCODE_I_TYPE_ALU) begin
            case (f3)
                3'b000:  b.alu_control = (b.r_type && ins[30]) ? ALU_SUB : ALU_ADD;
                3'b001:  b.alu_control = ALU_SLL;
                3'b010:  b.alu_control = ALU_SLT;
                3'b011:  b.alu_control = ALU_SLTU;
                3'b100:  b.alu_control = ALU_XOR;
                3'b101:  b.alu_control = ins[30] ? ALU_SRA : ALU_SRL;
                3'b110:  b.alu_control = ALU_OR;
                default: b.alu_control = ALU_AND;
            endcase
        end

        case (b.imm_source)
            IMM_S:   simm = $signed({ins[31:25], ins[11:7]});
            IMM_B:   simm = $signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0});
            IMM_J:   simm = $signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0});
            IMM_U:   simm = {ins[31:12], 12'h000};
            default: simm = $signed(ins[31:20]);
        endcase
        b.imm = simm;

        case (f3)
            BEQ:       taken = zero;
            BNE:       taken = !zero;
            BLT, BLTU: taken = last_bit;
            BGE, BGEU: taken = !last_bit;
            default:   taken = 1'b0;
        endcase
        b.pc_source = b.jump | (b.branch & taken);
        return b;
    endfunction

    // Model of the stage register, following the load and stall rule.
    always @(posedge clk) begin
        if (rst) begin
            exp_instr <= NOP_INSTR;
            exp_valid <= 1'b0;
        end else if (!stall) begin
            exp_instr <= instr;
            exp_valid <= in_valid;
        end
    end

    // Outputs are settled at the falling edge, half a period after any input change.
    always @(negedge clk) begin : compare
        bundle_t e;
        if (checking) begin
            e = decode_ref(exp_instr, alu_zero, alu_last_bit);
            check_bit("out_valid", exp_valid, out_valid);
            check_word("instr_q", exp_instr, instr_q);
            check_bit("mem_write", e.mem_write, mem_write);
            check_bit("reg_write", e.reg_write, reg_write);
            check_bit("alu_source", e.alu_source, alu_source);
            check_imm_src("imm_source", e.imm_source, imm_source);
            check_alu_op("alu_op", e.alu_op, alu_op);
            check_bit("r_type", e.r_type, r_type);
            check_bit("branch", e.branch, branch);
            check_bit("jump", e.jump, jump);
            check_bit("jalr", e.jalr, jalr);
            check_bit("lui", e.lui, lui);
            check_bit("auipc", e.auipc, auipc);
            check_bit("mem_to_reg", e.mem_to_reg, mem_to_reg);
            check_bit("illegal", e.illegal, illegal);
            check_alu("alu_control", e.alu_control, alu_control);
            check_bit("pc_source", e.pc_source, pc_source);
            check_word("imm", e.imm, imm);
        end
    end

    initial begin
        #(CLK_PERIOD * (N_ITEMS * 3 + 100));
        $display("Timeout: the run did not finish within %0d clock cycles.",
                 N_ITEMS * 3 + 100);
        report_failure();
    end

    initial begin
        word_t item;
        logic  item_valid;
        logic  held;
        seed_dummy = $urandom(87);
        checking = 1'b0;
        rst <= 1'b1;
        in_valid <= 1'b0;
        stall <= 1'b0;
        instr <= NOP_INSTR;
        alu_zero <= 1'b0;
        alu_last_bit <= 1'b0;
        @(posedge clk);
        checking = 1'b1;
        repeat (7) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < N_ITEMS; i++) begin
            item = make_instr($urandom_range(0, 9));
            item_valid = ($urandom_range(0, 4) != 0);
            do begin
                held = ($urandom_range(0, 2) == 0);
                stall <= held;
                // Junk on the inputs while stalled must never reach the stage register.
                if (held) begin
                    instr <= $urandom;
                    in_valid <= $urandom_range(0, 1);
                end else begin
                    instr <= item;
                    in_valid <= item_valid;
                end
                alu_zero <= $urandom_range(0, 1);
                alu_last_bit <= $urandom_range(0, 1);
                @(posedge clk);
            end while (held);
        end

        stall <= 1'b0;
        in_valid <= 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        $display("Testbench passed");
        $finish;
    end

endmodule
